// File: src/tile_sched_pkg.sv
// Tile scheduler definitions
package tile_sched_pkg;

  // Word address width toward memory
  parameter int unsigned ADDR_W = 32;

  // Width of loop counters and read counts
  parameter int unsigned CNT_W = 16;

  // Byte step between two neighbouring column tiles
  parameter int unsigned COL_JMP = 16;

  // X iteration word
  // Rows in the upper half, columns in the lower half
  typedef union packed {
    logic [2*CNT_W-1:0] raw;
    struct packed {
      logic [CNT_W-1:0] rows;
      logic [CNT_W-1:0] cols;
    } dims;
  } x_iters_u;

endpackage : tile_sched_pkg

// File: src/tile_cmd_if.sv
// Tile command channel
`timescale 1ns/1ps

interface tile_cmd_if;
  import tile_sched_pkg::*;

  logic              push;
  logic              full;
  logic              pop;
  logic [ADDR_W-1:0] base_addr;
  logic [CNT_W-1:0]  num_reads;
  logic              last_tile;

  // Side that offers commands
  modport producer (
    output push, base_addr, num_reads, last_tile,
    input  full, pop
  );

  // Side that takes commands
  modport consumer (
    input  push, base_addr, num_reads, last_tile,
    output full, pop
  );

endinterface : tile_cmd_if

// File: src/x_tile_scheduler.sv
// X tile scheduler
`timescale 1ns/1ps

module x_tile_scheduler #(
  parameter int unsigned ARRAY_W = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              start_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] x_addr_i,
  input  tile_sched_pkg::x_iters_u          x_iters_i,
  input  logic [tile_sched_pkg::CNT_W-1:0]  w_iters_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] rows_offs_i,
  input  logic [tile_sched_pkg::CNT_W-1:0]  leftover_i,
  output logic                              busy_o,
  tile_cmd_if.producer                      cmd_o
);
  import tile_sched_pkg::*;

  logic [CNT_W-1:0]  col_q, witer_q, row_q;
  logic [ADDR_W-1:0] col_offs_q, row_offs_q;
  logic              busy_q;
  logic              last_col, last_witer, last_row;
  logic              step;

  assign last_col   = col_q == x_iters_i.dims.cols - 1'b1;
  assign last_witer = witer_q == w_iters_i - 1'b1;
  assign last_row   = row_q == x_iters_i.dims.rows - 1'b1;

  // A command moves on only when the FIFO took it
  assign step = cmd_o.pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin : busy_register
    if (~rst_ni) begin
      busy_q <= 1'b0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
    end else if (step && cmd_o.last_tile) begin
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
    end
  end

  // Columns innermost
  always_ff @(posedge clk_i or negedge rst_ni) begin : col_register
    if (~rst_ni) begin
      col_q      <= '0;
      col_offs_q <= '0;
    end else if (clear_i) begin
      col_q      <= '0;
      col_offs_q <= '0;
    end else if (step) begin
      col_q      <= last_col ? '0 : col_q + 1'b1;
      col_offs_q <= last_col ? '0 : col_offs_q + ADDR_W'(COL_JMP);
    end
  end

  // W iterations wrap once per full column sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin : witer_register
    if (~rst_ni) begin
      witer_q <= '0;
    end else if (clear_i) begin
      witer_q <= '0;
    end else if (step && last_col) begin
      witer_q <= last_witer ? '0 : witer_q + 1'b1;
    end
  end

  // Rows outermost
  always_ff @(posedge clk_i or negedge rst_ni) begin : row_register
    if (~rst_ni) begin
      row_q      <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      row_q      <= '0;
      row_offs_q <= '0;
    end else if (step && last_col && last_witer) begin
      row_q      <= last_row ? '0 : row_q + 1'b1;
      row_offs_q <= last_row ? '0 : row_offs_q + rows_offs_i;
    end
  end

  assign cmd_o.push      = busy_q && !cmd_o.full;
  assign cmd_o.base_addr = x_addr_i + row_offs_q + col_offs_q;

  // Last row may be partial when leftover rows are set
  assign cmd_o.num_reads = (last_row && leftover_i != '0) ? leftover_i : CNT_W'(ARRAY_W);
  assign cmd_o.last_tile = last_col && last_witer && last_row;

  assign busy_o = busy_q;

endmodule : x_tile_scheduler

// File: src/tile_cmd_fifo.sv
// Tile command FIFO
`timescale 1ns/1ps

module tile_cmd_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  tile_cmd_if.consumer in_i,
  tile_cmd_if.producer out_o
);
  import tile_sched_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned ENTRY_W = ADDR_W + CNT_W + 1;

  logic [ENTRY_W-1:0]  mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                wr_en, rd_en;

  assign in_i.full = count_q == CNT_BITS'(FIFO_DEPTH);
  assign in_i.pop  = in_i.push && !in_i.full;
  assign wr_en     = in_i.pop;
  assign rd_en     = out_o.pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin : pointer_register
    if (~rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_BITS'(wr_en) - CNT_BITS'(rd_en);
    end
  end

  always_ff @(posedge clk_i) begin : storage
    if (wr_en) begin
      mem_q[wr_ptr_q] <= {in_i.last_tile, in_i.num_reads, in_i.base_addr};
    end
  end

  // Head entry is valid whenever something is stored
  assign out_o.push = count_q != '0;
  assign {out_o.last_tile, out_o.num_reads, out_o.base_addr} = mem_q[rd_ptr_q];

endmodule : tile_cmd_fifo

// File: src/x_addr_walker.sv
// X address walker
`timescale 1ns/1ps

module x_addr_walker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] d1_stride_i,
  input  logic                              mem_gnt_i,
  tile_cmd_if.consumer                      cmd_i,
  output logic [tile_sched_pkg::ADDR_W-1:0] addr_o,
  output logic                              addr_valid_o,
  output logic                              tile_last_o,
  output logic                              job_done_o
);
  import tile_sched_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  remain_q;
  logic              active_q;
  logic              last_tile_q;
  logic              final_addr;

  assign final_addr = active_q && remain_q == CNT_W'(1);

  // Ready when idle or when the last address of the tile is granted
  assign cmd_i.full = active_q && !(final_addr && mem_gnt_i);
  assign cmd_i.pop  = cmd_i.push && !cmd_i.full;

  always_ff @(posedge clk_i or negedge rst_ni) begin : control_register
    if (~rst_ni) begin
      active_q    <= 1'b0;
      remain_q    <= '0;
      last_tile_q <= 1'b0;
    end else if (clear_i) begin
      active_q    <= 1'b0;
      remain_q    <= '0;
      last_tile_q <= 1'b0;
    end else if (cmd_i.pop) begin
      active_q    <= 1'b1;
      remain_q    <= cmd_i.num_reads;
      last_tile_q <= cmd_i.last_tile;
    end else if (active_q && mem_gnt_i) begin
      active_q <= !final_addr;
      remain_q <= remain_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : addr_register
    if (cmd_i.pop) begin
      addr_q <= cmd_i.base_addr;
    end else if (active_q && mem_gnt_i) begin
      addr_q <= addr_q + d1_stride_i;
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = active_q;
  assign tile_last_o  = final_addr;
  assign job_done_o   = final_addr && last_tile_q && mem_gnt_i;

endmodule : x_addr_walker

// File: src/x_load_unit.sv
// X operand load unit
`timescale 1ns/1ps

module x_load_unit #(
  parameter int unsigned ARRAY_W    = 4,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              start_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] x_addr_i,
  input  logic [31:0]                       x_iters_i,
  input  logic [tile_sched_pkg::CNT_W-1:0]  w_iters_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] rows_offs_i,
  input  logic [tile_sched_pkg::CNT_W-1:0]  leftover_i,
  input  logic [tile_sched_pkg::ADDR_W-1:0] d1_stride_i,
  input  logic                              mem_gnt_i,
  output logic                              busy_o,
  output logic [tile_sched_pkg::ADDR_W-1:0] addr_o,
  output logic                              addr_valid_o,
  output logic                              tile_last_o,
  output logic                              job_done_o
);

  tile_cmd_if sched_if ();
  tile_cmd_if walk_if ();

  x_tile_scheduler #(
    .ARRAY_W (ARRAY_W)
  ) i_scheduler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_i     (start_i),
    .x_addr_i    (x_addr_i),
    .x_iters_i   (x_iters_i),
    .w_iters_i   (w_iters_i),
    .rows_offs_i (rows_offs_i),
    .leftover_i  (leftover_i),
    .busy_o      (busy_o),
    .cmd_o       (sched_if.producer)
  );

  tile_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .in_i    (sched_if.consumer),
    .out_o   (walk_if.producer)
  );

  x_addr_walker i_walker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .d1_stride_i  (d1_stride_i),
    .mem_gnt_i    (mem_gnt_i),
    .cmd_i        (walk_if.consumer),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .tile_last_o  (tile_last_o),
    .job_done_o   (job_done_o)
  );

endmodule : x_load_unit

// File: testbench/x_load_unit_asserts.sv
// X load unit port checks
`timescale 1ns/1ps

module x_load_unit_asserts (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              clear_i,
  input logic                              mem_gnt_i,
  input logic                              busy_o,
  input logic [tile_sched_pkg::ADDR_W-1:0] addr_o,
  input logic                              addr_valid_o,
  input logic                              tile_last_o,
  input logic                              job_done_o
);

  // Address holds until memory grants it
  addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !mem_gnt_i && !clear_i |=> $stable(addr_o))
    else $error("addr_o changed while waiting for grant");

  // Job ends on its final address with the scheduler idle and no address after it
  done_at_tile_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    job_done_o |-> tile_last_o && addr_valid_o && !busy_o ##1 !addr_valid_o)
    else $error("job_done_o away from the final address of an idle job");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(busy_o || addr_valid_o || tile_last_o || job_done_o))
    else $error("output active during reset");

endmodule : x_load_unit_asserts

bind x_load_unit x_load_unit_asserts i_asserts (.*);

// File: testbench/tb_x_load_unit.sv
// X load unit testbench
`timescale 1ns/1ps

module tb_x_load_unit;
  import tile_sched_pkg::*;

  localparam int ARRAY_W    = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_JOBS   = 18;
  localparam int FIELDS     = 9;
  // Jobs below this index see a constant grant
  localparam int FULL_GNT_JOBS = 6;
  localparam int CLEAR_JOB     = 13;

  logic              clk_i, rst_ni, clear_i, start_i, mem_gnt_i;
  logic [ADDR_W-1:0] x_addr_i, rows_offs_i, d1_stride_i, addr_o;
  logic [31:0]       x_iters_i;
  logic [CNT_W-1:0]  w_iters_i, leftover_i;
  logic              busy_o, addr_valid_o, tile_last_o, job_done_o;

  logic [31:0]       pat_mem [NUM_JOBS*FIELDS];
  logic [ADDR_W-1:0] exp_addr_q [$];
  logic              exp_last_q [$];
  logic              exp_done_q [$];
  logic [ADDR_W-1:0] done_addr;
  logic              full_gnt = 1'b1;
  int                seed = 93;
  int                tiles_seen;
  int                cols_seen;
  logic              tile_open;
  logic              col_run;
  int                errors = 0;
  int                limit_cycles = 0;

  x_load_unit #(.ARRAY_W(ARRAY_W), .FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

  function automatic logic [31:0] pat(input int job, input int field);
    return pat_mem[job*FIELDS+field];
  endfunction

  // Expected stream, rows outer, then W iterations, then columns
  function automatic void build_stream(input int job);
    int rows, cols, witers, left, n, r, w, c, k;
    logic [ADDR_W-1:0] base;
    rows   = pat(job, 1);
    cols   = pat(job, 2);
    witers = pat(job, 3);
    left   = pat(job, 5);
    exp_addr_q.delete();
    exp_last_q.delete();
    exp_done_q.delete();
    for (r = 0; r < rows; r++) begin
      for (w = 0; w < witers; w++) begin
        for (c = 0; c < cols; c++) begin
          base = pat(job, 0) + r * pat(job, 4) + c * COL_JMP;
          n = (r == rows - 1 && left != 0) ? left : ARRAY_W;
          for (k = 0; k < n; k++) begin
            exp_addr_q.push_back(base + k * pat(job, 6));
            exp_last_q.push_back(k == n - 1);
            exp_done_q.push_back(k == n - 1 && r == rows - 1 &&
                                 w == witers - 1 && c == cols - 1);
          end
        end
      end
    end
  endfunction

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] expected,
                            input logic [ADDR_W-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
      errors++;
      stop_with_failure();
    end
  endtask

  task automatic check_iters(input string name, input x_iters_u expected,
                             input x_iters_u actual);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected.raw, actual.raw);
      errors++;
      stop_with_failure();
    end
  endtask

  task automatic apply_config(input int job);
    logic [CNT_W-1:0] rows, cols;
    rows = pat(job, 1);
    cols = pat(job, 2);
    @(posedge clk_i);
    #1;
    full_gnt    = job < FULL_GNT_JOBS;
    x_addr_i    = pat(job, 0);
    x_iters_i   = {rows, cols};
    w_iters_i   = pat(job, 3);
    rows_offs_i = pat(job, 4);
    leftover_i  = pat(job, 5);
    d1_stride_i = pat(job, 6);
  endtask

  task automatic start_job();
    @(posedge clk_i);
    #1 start_i = 1'b1;
    @(posedge clk_i);
    #1 start_i = 1'b0;
    check_flag("busy_o", 1'b1, busy_o);
  endtask

  // Next granted address against the head of the model stream
  task automatic take_address();
    @(negedge clk_i);
    while (!(addr_valid_o && mem_gnt_i)) begin
      check_flag("job_done_o", 1'b0, job_done_o);
      @(negedge clk_i);
    end
    check_addr("addr_o", exp_addr_q.pop_front(), addr_o);
    check_flag("tile_last_o", exp_last_q.pop_front(), tile_last_o);
    check_flag("job_done_o", exp_done_q.pop_front(), job_done_o);
    if (tile_last_o) begin
      tiles_seen++;
    end
    if (job_done_o) begin
      done_addr = addr_o;
    end
    // Leading tiles one column jump apart give the column count
    if (tile_open && col_run) begin
      if (addr_o == x_addr_i + cols_seen * COL_JMP) begin
        cols_seen++;
      end else begin
        col_run = 1'b0;
      end
    end
    tile_open = tile_last_o;
  endtask

  task automatic run_job(input int job);
    x_iters_u want, seen;
    apply_config(job);
    build_stream(job);
    tiles_seen = 0;
    cols_seen  = 0;
    tile_open  = 1'b1;
    col_run    = 1'b1;
    done_addr  = 'x;
    start_job();
    while (exp_addr_q.size() > 0) begin
      take_address();
    end
    check_addr("tile count", pat(job, 7), tiles_seen);
    want.dims.rows = pat(job, 1);
    want.dims.cols = pat(job, 2);
    seen.dims.cols = cols_seen;
    seen.dims.rows = tiles_seen / (cols_seen * pat(job, 3));
    check_iters("tile shape", want, seen);
    check_addr("final address", pat(job, 8), done_addr);
    @(negedge clk_i);
    check_flag("addr_valid_o", 1'b0, addr_valid_o);
    check_flag("busy_o", 1'b0, busy_o);
  endtask

  task automatic clear_mid_job(input int job);
    apply_config(job);
    build_stream(job);
    start_job();
    repeat (7) take_address();
    @(posedge clk_i);
    #1 clear_i = 1'b1;
    @(posedge clk_i);
    #1 clear_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("addr_valid_o", 1'b0, addr_valid_o);
      check_flag("tile_last_o", 1'b0, tile_last_o);
      check_flag("job_done_o", 1'b0, job_done_o);
    end
    run_job(job);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : grant_driver
    #1;
    if (full_gnt) begin
      mem_gnt_i = 1'b1;
    end else begin
      mem_gnt_i = ($random(seed) & 3) != 0;
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: the jobs did not finish within %0d cycles", limit_cycles);
    stop_with_failure();
  end

  initial begin : main_sequence
    int total;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    mem_gnt_i   = 1'b0;
    x_addr_i    = '0;
    x_iters_i   = '0;
    w_iters_i   = '0;
    rows_offs_i = '0;
    leftover_i  = '0;
    d1_stride_i = '0;
    total       = 0;
    $readmemh("testbench/x_load_patterns.txt", pat_mem);
    for (int j = 0; j < NUM_JOBS; j++) begin
      build_stream(j);
      total += exp_addr_q.size();
    end
    build_stream(CLEAR_JOB);
    total += 2 * exp_addr_q.size();
    limit_cycles = 20 * total + 200;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    clear_mid_job(CLEAR_JOB);
    if (errors == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule : tb_x_load_unit

// File: testbench/x_load_patterns.txt
// x_addr rows cols w_iters rows_offs leftover d1_stride tiles final_addr
// All values hex, one job per line
// Constant grant
00001000 0001 0001 0001 00000100 0000 00000004 0001 0000100C
00002000 0002 0003 0001 00000200 0000 00000004 0006 0000222C
00003000 0003 0002 0002 00000100 0002 00000008 000C 00003218
00004000 0002 0002 0003 00000040 0001 00000010 000C 00004050
00000000 0004 0001 0001 00000020 0003 00000004 0004 00000068
00008000 0001 0004 0002 00001000 0002 00000100 0008 00008130
// Random grant
00001000 0002 0002 0002 00000080 0000 00000004 0008 0000109C
0000A000 0003 0003 0001 00000300 0002 00000020 0009 0000A640
00005000 0002 0001 0004 00000010 0000 00000001 0008 00005013
0000C000 0005 0002 0001 00000040 0001 00000008 000A 0000C110
00000100 0001 0001 0003 00000000 0000 00000004 0003 0000010C
00002000 0003 0004 0002 00000400 0003 00000004 0018 00002838
0000FFF0 0002 0002 0001 00000010 0000 00000004 0004 0001001C
00007000 0004 0003 0002 00000100 0002 00000010 0018 00007330
00003000 0002 0005 0001 00000200 0000 00000002 000A 00003246
00009000 0003 0002 0003 00000080 0003 00000004 0012 00009118
00006000 0002 0003 0002 00000100 0001 00000004 000C 00006120
0000B000 0006 0001 0002 00000020 0000 00000008 000C 0000B0B8

// File: build.f
src/tile_sched_pkg.sv
src/tile_cmd_if.sv
src/x_tile_scheduler.sv
src/tile_cmd_fifo.sv
src/x_addr_walker.sv
src/x_load_unit.sv
testbench/x_load_unit_asserts.sv
testbench/tb_x_load_unit.sv
